//--- include/cdr_macros.svh
`ifndef CDR_MACROS_SVH
`define CDR_MACROS_SVH

//////////////////////////////////////////////////
// Word geometry

// Samples per word at 4x oversampling
`define CDR_SAMPLE_W 16

// Edge flags of this word and the word before it
`define CDR_EDGE_HIST_W 32

// Index of a sample inside one word
`define CDR_PTR_W 4

//////////////////////////////////////////////////
// Recovered data

// At most five bits fit in 16 samples with short runs
`define CDR_DATA_W 5
`define CDR_COUNT_W 3
`define CDR_NUM_SLICES 5

// Set to 1 to flip the polarity of every sample
`define CDR_INVERT 0

`endif

//--- logic/cdr_pkg.sv
`include "cdr_macros.svh"

package cdr_pkg;

	//////////////////////////////////////////////////
	// Sample word

	// Bit 15 is the earliest sample in time
	typedef logic [`CDR_SAMPLE_W-1:0] sample_word_t;

	//////////////////////////////////////////////////
	// State handed from one bit slice to the next

	typedef struct packed {
		// Samples of the word being sliced
		sample_word_t samples;
		// Flag i set when sample i differs from sample i+1
		logic [`CDR_SAMPLE_W-1:0] edges;
		// Next sampling point
		logic [`CDR_PTR_W-1:0] start;
		// Newest bit in the LSB
		logic [`CDR_DATA_W-1:0] data;
		logic [`CDR_COUNT_W-1:0] count;
		// No sampling point left inside this word
		logic done;
	} slice_state_t;

endpackage

//--- logic/cdr_edge_search.sv
`timescale 1ns/1ps
`include "cdr_macros.svh"

module cdr_edge_search (
	input logic clk_312p5mhz,
	input logic arst_n,
	input cdr_pkg::sample_word_t samples,
	output cdr_pkg::slice_state_t state
);

	import cdr_pkg::*;

	// Samples after the polarity option
	sample_word_t samples_pol;

	// Flags 31:16 belong to the previous word, 15:0 to this one
	logic [`CDR_EDGE_HIST_W-1:0] edge_hist;

	// Split run seen by the previous word already
	logic run_2p3;
	logic run_6p3;
	// Corrections for an edge at index 12 or 13
	logic round_12;
	logic round_13;

	// Fallback search results
	logic found;
	logic [1:0] edge_phase;

	slice_state_t state_d;
	slice_state_t state_q;

	//////////////////////////////////////////////////
	// Polarity and edge detection

	assign samples_pol = (`CDR_INVERT != 0) ? ~samples : samples;

	// Previous word's flags and its last sample come from the output register
	assign edge_hist[`CDR_EDGE_HIST_W-1:`CDR_SAMPLE_W] = state_q.edges;
	assign edge_hist[`CDR_SAMPLE_W-1] = samples_pol[`CDR_SAMPLE_W-1] ^ state_q.samples[0];
	assign edge_hist[`CDR_SAMPLE_W-2:0] =
		samples_pol[`CDR_SAMPLE_W-2:0] ^ samples_pol[`CDR_SAMPLE_W-1:1];

	//////////////////////////////////////////////////
	// Split run handling near the word boundary

	// Runs of 2+3 or 6+3 were already sliced in the previous word
	assign run_2p3 = (edge_hist[20:15] == '0) && edge_hist[21];
	assign run_6p3 = (edge_hist[24:15] == '0) && edge_hist[25];

	// Runs of 3+3 or 4+3 round up to two bits and 1+3 to one bit
	assign round_12 = !run_2p3 && !run_6p3 &&
		((edge_hist[17:15] == '0) || edge_hist[16]);

	// Runs of 5+2 and 6+2 give two bits and 1+2 gives one
	assign round_13 = (edge_hist[19:14] == '0) || edge_hist[16];

	//////////////////////////////////////////////////
	// First sampling point

	always_comb begin
		found = 1'b0;
		edge_phase = 2'd0;

		// Look back into the previous word, nearest edge first
		for (int i = `CDR_SAMPLE_W; i < `CDR_EDGE_HIST_W - 1; i++) begin
			if (edge_hist[i] && !found) begin
				found = 1'b1;
				edge_phase = 2'(i);
			end
		end

		// Then forward through the rest of this word
		for (int i = `CDR_SAMPLE_W - 5; i >= 0; i--) begin
			if (edge_hist[i] && !found) begin
				found = 1'b1;
				edge_phase = 2'(i);
			end
		end

		state_d = '0;
		state_d.samples = samples_pol;
		state_d.edges = edge_hist[`CDR_SAMPLE_W-1:0];

		// An edge in the first four samples wins
		if (edge_hist[15]) begin
			state_d.start = 4'd14;
		end else if (edge_hist[14]) begin
			state_d.start = 4'd13;
		end else if (edge_hist[13]) begin
			state_d.start = round_13 ? 4'd15 : 4'd12;
		end else if (edge_hist[12]) begin
			state_d.start = round_12 ? 4'd15 : 4'd11;
		end else begin
			// One sample after the edge, modulo 4
			case (edge_phase)
				2'd0: state_d.start = 4'd15;
				2'd1: state_d.start = 4'd12;
				2'd2: state_d.start = 4'd13;
				default: state_d.start = 4'd14;
			endcase
		end
	end

	always_ff @(posedge clk_312p5mhz or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= '0;
		end else begin
			state_q <= state_d;
		end
	end

	assign state = state_q;

endmodule

//--- logic/cdr_bit_slice.sv
`timescale 1ns/1ps
`include "cdr_macros.svh"

module cdr_bit_slice (
	input logic clk_312p5mhz,
	input logic arst_n,
	input cdr_pkg::slice_state_t state_in,
	output cdr_pkg::slice_state_t state_out
);

	import cdr_pkg::*;

	// Edges at fixed distances behind the sampling point
	logic edge_m1;
	logic edge_m2;
	logic edge_m3;
	logic edge_m4;

	// Sample is taken in this stage
	logic take;
	// Distance to the next sampling point
	logic [2:0] step;

	slice_state_t state_d;

	//////////////////////////////////////////////////
	// Edge lookup

	// Indices below zero fall outside the word and never hold an edge
	assign edge_m1 = (state_in.start >= `CDR_PTR_W'(1)) &&
		state_in.edges[state_in.start - `CDR_PTR_W'(1)];
	assign edge_m2 = (state_in.start >= `CDR_PTR_W'(2)) &&
		state_in.edges[state_in.start - `CDR_PTR_W'(2)];
	assign edge_m3 = (state_in.start >= `CDR_PTR_W'(3)) &&
		state_in.edges[state_in.start - `CDR_PTR_W'(3)];
	assign edge_m4 = (state_in.start >= `CDR_PTR_W'(4)) &&
		state_in.edges[state_in.start - `CDR_PTR_W'(4)];

	// First bit is skipped when an edge follows right after it
	assign take = !state_in.done && !((state_in.count == '0) && edge_m1);

	// Next edge is expected 3 to 5 samples on, else assume 4
	assign step = edge_m2 ? 3'd3 :
		edge_m3 ? 3'd4 :
		edge_m4 ? 3'd5 : 3'd4;

	//////////////////////////////////////////////////
	// Slice one bit

	always_comb begin
		state_d = state_in;
		if (take) begin
			state_d.data = {state_in.data[`CDR_DATA_W-2:0], state_in.samples[state_in.start]};
			state_d.count = state_in.count + `CDR_COUNT_W'(1);
			state_d.start = state_in.start - `CDR_PTR_W'(step);
			// Next point lies in the following word
			state_d.done = state_in.start < `CDR_PTR_W'(step);
		end
	end

	always_ff @(posedge clk_312p5mhz or negedge arst_n) begin
		if (!arst_n) begin
			state_out <= '0;
		end else begin
			state_out <= state_d;
		end
	end

endmodule

//--- logic/cdr_rx_top.sv
`timescale 1ns/1ps
`include "cdr_macros.svh"

module cdr_rx_top (
	input logic clk_312p5mhz,
	input logic arst_n,
	input cdr_pkg::sample_word_t samples,
	output logic [`CDR_DATA_W-1:0] rx_data,
	output logic [`CDR_COUNT_W-1:0] rx_data_count
);

	import cdr_pkg::*;

	// Entry 0 leaves the edge search, entry N leaves the last slice
	slice_state_t stage_state [0:`CDR_NUM_SLICES];

	//////////////////////////////////////////////////
	// Edge search and first sampling point

	cdr_edge_search edge_search_i (
		.clk_312p5mhz(clk_312p5mhz),
		.arst_n(arst_n),
		.samples(samples),
		.state(stage_state[0])
	);

	//////////////////////////////////////////////////
	// Bit slice chain

	// One bit per stage
	// The fifth stage only fires on short runs
	for (genvar g = 0; g < `CDR_NUM_SLICES; g++) begin : g_slice
		cdr_bit_slice bit_slice_i (
			.clk_312p5mhz(clk_312p5mhz),
			.arst_n(arst_n),
			.state_in(stage_state[g]),
			.state_out(stage_state[g+1])
		);
	end

	//////////////////////////////////////////////////
	// Outputs

	assign rx_data = stage_state[`CDR_NUM_SLICES].data;
	assign rx_data_count = stage_state[`CDR_NUM_SLICES].count;

endmodule

//--- verification/cdr_rx_properties.sv
`timescale 1ns/1ps
`include "cdr_macros.svh"

module cdr_rx_properties (
	input logic clk_312p5mhz,
	input logic arst_n,
	input logic [`CDR_DATA_W-1:0] rx_data,
	input logic [`CDR_COUNT_W-1:0] rx_data_count
);

	//////////////////////////////////////////////////
	// Output rules of the slice chain

	// One bit per slice at most
	property count_in_range;
		@(posedge clk_312p5mhz) disable iff (!arst_n)
			rx_data_count <= `CDR_COUNT_W'(`CDR_NUM_SLICES);
	endproperty

	// Registers held clear during reset
	property outputs_clear_in_reset;
		@(posedge clk_312p5mhz) !arst_n |-> (rx_data == '0 && rx_data_count == '0);
	endproperty

	// Data shifts in from the LSB, so unused upper bits stay clear
	property data_above_count_clear;
		@(posedge clk_312p5mhz) disable iff (!arst_n)
			(rx_data >> rx_data_count) == '0;
	endproperty

	count_in_range_a: assert property (count_in_range)
		else $error("rx_data_count exceeds the number of slices");
	outputs_clear_in_reset_a: assert property (outputs_clear_in_reset)
		else $error("outputs not clear while arst_n is low");
	data_above_count_clear_a: assert property (data_above_count_clear)
		else $error("rx_data has bits set above rx_data_count");

endmodule

bind cdr_rx_top cdr_rx_properties cdr_rx_properties_i (
	.clk_312p5mhz(clk_312p5mhz),
	.arst_n(arst_n),
	.rx_data(rx_data),
	.rx_data_count(rx_data_count)
);

//--- verification/cdr_rx_tb.sv
`timescale 1ns/1ps
`include "cdr_macros.svh"

module cdr_rx_tb;

	import cdr_pkg::*;

	localparam int CLK_PERIOD = 200;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 3;
	localparam int LATENCY = 6;
	localparam int TABLE_LEN = 10;
	localparam int RANDOM_WORDS = 96;
	localparam int TOTAL_WORDS = TABLE_LEN + RANDOM_WORDS;

	typedef struct packed {
		sample_word_t word;
		logic [`CDR_COUNT_W-1:0] count;
		logic [`CDR_DATA_W-1:0] data;
	} table_entry_t;

	// Edges are kept so the next word can look back
	typedef struct packed {
		logic [`CDR_SAMPLE_W-1:0] edges;
		logic [`CDR_COUNT_W-1:0] count;
		logic [`CDR_DATA_W-1:0] data;
	} model_result_t;

	logic clk_312p5mhz;
	logic arst_n;
	sample_word_t samples;
	logic [`CDR_DATA_W-1:0] rx_data;
	logic [`CDR_COUNT_W-1:0] rx_data_count;

	// Constant and nibble words, each twice so the history repeats
	table_entry_t stim_table [TABLE_LEN] = '{
		'{16'hFFFF, 3'd4, 5'h0F},
		'{16'hFFFF, 3'd4, 5'h0F},
		'{16'h0000, 3'd4, 5'h00},
		'{16'h0000, 3'd4, 5'h00},
		'{16'hF0F0, 3'd4, 5'h0A},
		'{16'hF0F0, 3'd4, 5'h0A},
		'{16'h0F0F, 3'd4, 5'h05},
		'{16'h0F0F, 3'd4, 5'h05},
		'{16'h0000, 3'd4, 5'h00},
		'{16'hFFFF, 3'd4, 5'h0F}
	};

	sample_word_t words [TOTAL_WORDS];
	model_result_t expected [TOTAL_WORDS];
	logic [31:0] rng_state;
	int run_left;
	logic run_bit;
	int seen_count3;
	int seen_count5;

	cdr_rx_top cdr_rx_top_i (
		.clk_312p5mhz(clk_312p5mhz),
		.arst_n(arst_n),
		.samples(samples),
		.rx_data(rx_data),
		.rx_data_count(rx_data_count)
	);

	initial begin
		clk_312p5mhz = 1'b0;
		forever #(CLK_PERIOD / 2) clk_312p5mhz = ~clk_312p5mhz;
	end

	//////////////////////////////////////////////////
	// Stimulus and reference model

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Mode 0 alternates runs of 3, mode 1 runs of 5, mode 2 random bits and runs of 3 to 5
	task automatic make_jittered_word(input int mode, output sample_word_t w);
		for (int b = `CDR_SAMPLE_W - 1; b >= 0; b--) begin
			if (run_left == 0) begin
				rng_state = xorshift32(rng_state);
				run_bit = (mode == 2) ? rng_state[0] : ~run_bit;
				run_left = (mode == 0) ? 3 : (mode == 1) ? 5 : 3 + int'(rng_state[15:8]) % 3;
			end
			w[b] = run_bit;
			run_left--;
		end
	endtask

	function automatic logic edge_at(input logic [`CDR_SAMPLE_W-1:0] edges, input int idx);
		return (idx >= 0) ? edges[idx] : 1'b0;
	endfunction

	// Run the bit slicing rules over a number of stages
	function automatic model_result_t slice_chain(input sample_word_t w,
		input logic [`CDR_SAMPLE_W-1:0] edges, input int start, input int stages);
		model_result_t res;
		int ptr;
		int step;
		logic ended;
		res = '0;
		res.edges = edges;
		ptr = start;
		ended = 1'b0;
		for (int s = 0; s < stages; s++) begin
			// First bit waits when an edge sits right behind it
			if (!ended && !(res.count == '0 && edge_at(edges, ptr - 1))) begin
				res.data = {res.data[`CDR_DATA_W-2:0], w[ptr]};
				res.count = res.count + 3'd1;
				step = edge_at(edges, ptr - 2) ? 3 :
					edge_at(edges, ptr - 3) ? 4 :
					edge_at(edges, ptr - 4) ? 5 : 4;
				ended = (ptr - step) < 0;
				ptr = ptr - step;
			end
		end
		return res;
	endfunction

	function automatic model_result_t reference_model(input sample_word_t raw,
		input sample_word_t prev_raw, input logic [`CDR_SAMPLE_W-1:0] prev_edges);
		sample_word_t w;
		sample_word_t p;
		logic [`CDR_EDGE_HIST_W-1:0] hist;
		logic split_run;
		int edge_idx;
		int start;
		w = (`CDR_INVERT != 0) ? ~raw : raw;
		p = (`CDR_INVERT != 0) ? ~prev_raw : prev_raw;
		hist[31:16] = prev_edges;
		hist[15] = w[15] ^ p[0];
		for (int i = 0; i < 15; i++) begin
			hist[i] = w[i] ^ w[i + 1];
		end
		// Runs of 2+3 or 6+3 across the boundary
		split_run = (hist[20:15] == '0 && hist[21]) || (hist[24:15] == '0 && hist[25]);
		edge_idx = -1;
		for (int i = 12; i <= 15; i++) begin
			if (hist[i]) edge_idx = i;
		end
		if (edge_idx >= 0) begin
			start = edge_idx - 1;
			if (edge_idx == 13 && (hist[19:14] == '0 || hist[16])) start = 15;
			if (edge_idx == 12 && !split_run && (hist[17:15] == '0 || hist[16])) start = 15;
		end else begin
			// Nearest edge back in the previous word, else the highest one here
			for (int i = 30; i >= 16; i--) begin
				if (hist[i]) edge_idx = i;
			end
			for (int i = 11; i >= 0 && edge_idx < 0; i--) begin
				if (hist[i]) edge_idx = i;
			end
			start = (edge_idx < 0) ? 15 : 12 + (edge_idx + 3) % 4;
		end
		return slice_chain(w, hist[15:0], start, `CDR_NUM_SLICES);
	endfunction

	//////////////////////////////////////////////////
	// Checks

	task automatic report_mismatch(input string name, input int exp_val, input int act_val);
		$display("FAIL at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp_val, act_val);
		$display("TEST FAILED");
		$fatal(1, "output mismatch");
	endtask

	task automatic stop_with_error(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_outputs(input int count_exp, input int data_exp);
		assert (int'(rx_data_count) == count_exp)
			else report_mismatch("rx_data_count", count_exp, int'(rx_data_count));
		assert (int'(rx_data) == data_exp)
			else report_mismatch("rx_data", data_exp, int'(rx_data));
	endtask

	initial begin
		#((TOTAL_WORDS + 20) * CLK_PERIOD);
		$display("ERROR at %0t ns: watchdog expired before all words were checked", $time);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		model_result_t res;
		sample_word_t prev_word;
		logic [`CDR_SAMPLE_W-1:0] prev_edges;
		int idx;
		arst_n = 1'b0;
		samples = '0;
		rng_state = 32'h9626a954;
		run_left = 0;
		run_bit = 1'b0;
		seen_count3 = 0;
		seen_count5 = 0;
		prev_word = '0;
		prev_edges = '0;
		// Table words, then blocks of eight jittered words per mode
		for (int k = 0; k < TOTAL_WORDS; k++) begin
			if (k < TABLE_LEN) words[k] = stim_table[k].word;
			else make_jittered_word(((k - TABLE_LEN) / 8) % 3, words[k]);
			res = reference_model(words[k], prev_word, prev_edges);
			expected[k] = res;
			prev_word = words[k];
			prev_edges = res.edges;
			if (k < TABLE_LEN) begin
				assert (res.count == stim_table[k].count && res.data == stim_table[k].data)
					else stop_with_error($sformatf("model disagrees with table entry %0d", k));
			end
		end
		for (int r = 0; r < RESET_CYCLES; r++) begin
			#(CLK_PERIOD / 4);
			check_outputs(0, 0);
			@(posedge clk_312p5mhz);
		end
		// Reset lifts together with the first word
		for (int c = 0; c < TOTAL_WORDS + LATENCY; c++) begin
			#(DRIVE_DELAY);
			arst_n = 1'b1;
			samples = (c < TOTAL_WORDS) ? words[c] : '0;
			#(CLK_PERIOD * 3 / 4 - DRIVE_DELAY);
			if (c < LATENCY) begin
				// Cleared states drain out of the chain ahead of word 0
				res = slice_chain('0, '0, 0, c);
			end else begin
				idx = c - LATENCY;
				res = expected[idx];
				if (idx >= TABLE_LEN && res.count == 3'd3) seen_count3++;
				if (idx >= TABLE_LEN && res.count == 3'd5) seen_count5++;
			end
			check_outputs(int'(res.count), int'(res.data));
			@(posedge clk_312p5mhz);
		end
		if (seen_count3 > 0 && seen_count5 > 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("ERROR: jittered words never produced both 3 and 5 bits in a word");
			$display("TEST FAILED");
			$fatal(1, "bit count coverage missing");
		end
	end

endmodule

//--- cdr_rx.f
+incdir+include
logic/cdr_pkg.sv
logic/cdr_edge_search.sv
logic/cdr_bit_slice.sv
logic/cdr_rx_top.sv
verification/cdr_rx_properties.sv
verification/cdr_rx_tb.sv

//--- Makefile
# Verilator flow for the CDR receiver core
TOP = cdr_rx_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f cdr_rx.f --top-module $(TOP)

# The run log decides the result, a missing pass line fails the target
sim:
	verilator --binary --timing --assert -f cdr_rx.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TEST PASSED" sim.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
